// File: verilog/ppu_cfg_pkg.sv
// Configuration package: register map, filter codes, CTRL/FILTER fields and config struct
package ppu_cfg_pkg;

  // Wishbone data width
  localparam int WB_DW = 8;

  // Register map, STATUS is read-only
  typedef enum logic [1:0] {
    CFG_CTRL   = 2'd0,
    CFG_FILTER = 2'd1,
    CFG_STATUS = 2'd2
  } cfg_addr_e;

  // Filter select as written by software
  typedef enum logic [2:0] {
    FILT_AUTO   = 3'd0,
    FILT_SD     = 3'd1,
    FILT_ED     = 3'd2,
    FILT_HD     = 3'd3,
    FILT_BYPASS = 3'd4
  } filter_sel_e;

  // CTRL register bits
  localparam int CTRL_TESTPAT  = 0;
  localparam int CTRL_EXCH_RB  = 1;
  localparam int CTRL_EN_YPBPR = 2;
  localparam int CTRL_EN_RGSB  = 3;
  localparam int CTRL_VGA_SYNC = 4;

  // FILTER register fields
  localparam int FILT_SEL_MSB = 2;
  localparam int FILT_SEL_LSB = 0;
  localparam int LINEMULT_MSB = 5;
  localparam int LINEMULT_LSB = 4;

  // Live configuration seen by the pixel pipeline
  typedef struct packed {
    logic        testpat;
    logic        exchange_rb;
    logic        en_ypbpr;
    logic        en_rgsb;
    logic        use_vga_hvsync;
    filter_sel_e filter_sel;
    logic [1:0]  linemult;
  } ppu_cfg_t;

endpackage

// File: verilog/ppu_video_pkg.sv
// Video package: sync bit indices, line tracker states and YPbPr matrix coefficients
package ppu_video_pkg;

  // Sync vector bits, all active low
  // Bit 2 carries the blank flag and is passed along untouched
  localparam int SYNC_C = 0;
  localparam int SYNC_H = 1;
  localparam int SYNC_V = 3;

  // Line/frame tracker states
  typedef enum logic [1:0] {
    WAIT_FRAME = 2'd0,
    VSYNC      = 2'd1,
    ACTIVE     = 2'd2,
    HSYNC      = 2'd3
  } line_state_e;

  // Coefficients are scaled by 2^COEF_SHIFT
  localparam int COEF_W     = 10;
  localparam int COEF_SHIFT = 8;

  // Row order Y, Pb, Pr; column order R, G, B
  localparam logic signed [COEF_W-1:0] YPBPR_COEF [9] = '{
    10'sd77,   10'sd150,  10'sd29,
    -10'sd43,  -10'sd85,  10'sd128,
    10'sd128,  -10'sd107, -10'sd21
  };

endpackage

// File: verilog/ppu_video_if.sv
// Pixel stream interface with source and sink modports
`timescale 1ns/1ps

interface ppu_video_if #(
  parameter int COLOR_W = 8
);

  // One pixel per valid cycle, no back-pressure
  logic               valid;
  logic [COLOR_W-1:0] r;
  logic [COLOR_W-1:0] g;
  logic [COLOR_W-1:0] b;
  // Active-low sync bits, indexed by ppu_video_pkg
  logic [3:0]         sync;

  modport src (output valid, r, g, b, sync);
  modport snk (input valid, r, g, b, sync);

endinterface

// File: verilog/ppu_cfg_wb.sv
// Wishbone classic register bank: CTRL and FILTER configuration, STATUS line count
`timescale 1ns/1ps

module ppu_cfg_wb (
  input  logic                          VCLK_Tx,
  input  logic                          nVRST_Tx,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [1:0]                    wb_adr_i,
  input  logic [ppu_cfg_pkg::WB_DW-1:0] wb_dat_i,
  output logic [ppu_cfg_pkg::WB_DW-1:0] wb_dat_o,
  output logic                          wb_ack_o,
  input  logic [7:0]                    frame_lines_i,
  output ppu_cfg_pkg::ppu_cfg_t         cfg_o
);

  import ppu_cfg_pkg::*;

  cfg_addr_e        adr;
  logic             req;
  logic [WB_DW-1:0] rd_data;

  assign adr = cfg_addr_e'(wb_adr_i);
  // New request only while ack is low, so each access acks once
  assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  // ========================================
  // Ack and register writes
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      wb_ack_o <= 1'b0;
      cfg_o    <= '0;
    end else begin
      wb_ack_o <= req;
      // Write lands on the same edge that raises ack
      if (req && wb_we_i) begin
        case (adr)
          CFG_CTRL: begin
            cfg_o.testpat        <= wb_dat_i[CTRL_TESTPAT];
            cfg_o.exchange_rb    <= wb_dat_i[CTRL_EXCH_RB];
            cfg_o.en_ypbpr       <= wb_dat_i[CTRL_EN_YPBPR];
            cfg_o.en_rgsb        <= wb_dat_i[CTRL_EN_RGSB];
            cfg_o.use_vga_hvsync <= wb_dat_i[CTRL_VGA_SYNC];
          end
          CFG_FILTER: begin
            cfg_o.filter_sel <= filter_sel_e'(wb_dat_i[FILT_SEL_MSB:FILT_SEL_LSB]);
            cfg_o.linemult   <= wb_dat_i[LINEMULT_MSB:LINEMULT_LSB];
          end
          // STATUS and unmapped addresses drop the write
          default: ;
        endcase
      end
    end
  end

  // ========================================
  // Read mux
  // ========================================

  always_comb begin
    rd_data = '0;
    case (adr)
      CFG_CTRL: begin
        rd_data[CTRL_TESTPAT]  = cfg_o.testpat;
        rd_data[CTRL_EXCH_RB]  = cfg_o.exchange_rb;
        rd_data[CTRL_EN_YPBPR] = cfg_o.en_ypbpr;
        rd_data[CTRL_EN_RGSB]  = cfg_o.en_rgsb;
        rd_data[CTRL_VGA_SYNC] = cfg_o.use_vga_hvsync;
      end
      CFG_FILTER: begin
        rd_data[FILT_SEL_MSB:FILT_SEL_LSB] = cfg_o.filter_sel;
        rd_data[LINEMULT_MSB:LINEMULT_LSB] = cfg_o.linemult;
      end
      // Low byte of the last frame's line count
      CFG_STATUS: rd_data = frame_lines_i;
      default:    rd_data = '0;
    endcase
  end

  // Master holds adr, so data is stable for the whole ack cycle
  assign wb_dat_o = wb_ack_o ? rd_data : '0;

endmodule

// File: verilog/ppu_line_fsm.sv
// Line/frame tracker: sync edge detection and line state FSM
`timescale 1ns/1ps

module ppu_line_fsm (
  input  logic       VCLK_Tx,
  input  logic       nVRST_Tx,
  input  logic       vdata_valid_i,
  input  logic [3:0] vsync_i,
  output logic       line_start_o,
  output logic       frame_start_o,
  output logic       in_frame_o
);

  import ppu_video_pkg::*;

  line_state_e state_q;
  line_state_e state_d;
  // H and V sync of the previous valid pixel
  logic        prev_h;
  logic        prev_v;

  // Falling edges, decoded on the current pixel without delay
  assign line_start_o  = vdata_valid_i & ~vsync_i[SYNC_H] & prev_h;
  assign frame_start_o = vdata_valid_i & ~vsync_i[SYNC_V] & prev_v;

  // Any state past WAIT_FRAME means a frame has begun
  assign in_frame_o = (state_q != WAIT_FRAME);

  always_comb begin
    state_d = state_q;
    if (frame_start_o) begin
      state_d = VSYNC;
    end else if (vdata_valid_i) begin
      case (state_q)
        // Leave V sync on its trailing edge
        VSYNC:   if (vsync_i[SYNC_V]) state_d = ACTIVE;
        ACTIVE:  if (!vsync_i[SYNC_H]) state_d = HSYNC;
        HSYNC:   if (vsync_i[SYNC_H]) state_d = ACTIVE;
        default: state_d = state_q;
      endcase
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      state_q <= WAIT_FRAME;
      // Idle level of active-low syncs
      prev_h  <= 1'b1;
      prev_v  <= 1'b1;
    end else if (vdata_valid_i) begin
      state_q <= state_d;
      prev_h  <= vsync_i[SYNC_H];
      prev_v  <= vsync_i[SYNC_V];
    end
  end

endmodule

// File: verilog/ppu_pos_counter.sv
// Column and line counters with line count capture of the finished frame
`timescale 1ns/1ps

module ppu_pos_counter #(
  parameter int POS_W = 10
) (
  input  logic             VCLK_Tx,
  input  logic             nVRST_Tx,
  input  logic             vdata_valid_i,
  input  logic             line_start_i,
  input  logic             frame_start_i,
  input  logic             in_frame_i,
  output logic [POS_W-1:0] x_o,
  output logic [POS_W-1:0] y_o,
  output logic [7:0]       frame_lines_o
);

  // Position of the previous valid pixel
  logic [POS_W-1:0] x_q;
  logic [POS_W-1:0] y_q;

  // Current pixel position, start pulses take effect right away
  assign x_o = line_start_i ? '0 : x_q + 1'b1;
  always_comb begin
    if (frame_start_i) begin
      y_o = '0;
    end else if (line_start_i) begin
      y_o = y_q + 1'b1;
    end else begin
      y_o = y_q;
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      x_q           <= '0;
      y_q           <= '0;
      frame_lines_o <= '0;
    end else if (vdata_valid_i) begin
      x_q <= x_o;
      y_q <= y_o;
      // Last line index plus one, skipped for the first frame
      if (frame_start_i && in_frame_i) begin
        frame_lines_o <= 8'(y_q + 1'b1);
      end
    end
  end

endmodule

// File: verilog/ppu_testpat.sv
// Input stage: pixel register with optional checkerboard test pattern
`timescale 1ns/1ps

module ppu_testpat #(
  parameter int COLOR_W = 8,
  parameter int POS_W   = 10
) (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  logic                 vdata_valid_i,
  input  logic [3*COLOR_W-1:0] vd_i,
  input  logic [3:0]           vsync_i,
  input  logic [POS_W-1:0]     x_i,
  input  logic [POS_W-1:0]     y_i,
  input  ppu_cfg_pkg::ppu_cfg_t cfg_i,
  ppu_video_if.src             vid_o
);

  // 8x8 checker tile, lit where column and line tiles differ
  logic               tile_on;
  logic [COLOR_W-1:0] tile_val;

  assign tile_on  = x_i[3] ^ y_i[3];
  assign tile_val = tile_on ? '1 : '0;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vid_o.valid <= 1'b0;
    end else begin
      vid_o.valid <= vdata_valid_i;
    end
  end

  // Payload, red in the top third of vd_i
  always_ff @(posedge VCLK_Tx) begin
    vid_o.sync <= vsync_i;
    if (cfg_i.testpat) begin
      vid_o.r <= tile_val;
      vid_o.g <= tile_val;
      vid_o.b <= tile_val;
    end else begin
      vid_o.r <= vd_i[3*COLOR_W-1:2*COLOR_W];
      vid_o.g <= vd_i[2*COLOR_W-1:COLOR_W];
      vid_o.b <= vd_i[COLOR_W-1:0];
    end
  end

endmodule

// File: verilog/ppu_vconv.sv
// Two-stage RGB to YPbPr matrix with bypass
`timescale 1ns/1ps

module ppu_vconv #(
  parameter int COLOR_W = 8
) (
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,
  input  ppu_cfg_pkg::ppu_cfg_t cfg_i,
  ppu_video_if.snk              vid_i,
  ppu_video_if.src              vid_o
);

  import ppu_video_pkg::*;

  // Product and sum widths, sign bit included
  localparam int PW = COLOR_W + COEF_W + 1;
  localparam int SW = PW + 2;
  localparam logic signed [SW-1:0] OFFSET = SW'(2 ** (COLOR_W - 1));
  localparam logic signed [SW-1:0] MAXV   = SW'(2 ** COLOR_W - 1);

  logic [COLOR_W-1:0]   pix_in [3];
  logic [COLOR_W-1:0]   rgb_d  [3];
  logic signed [PW-1:0] prod   [9];
  logic signed [SW-1:0] sum    [3];
  logic [3:0]           sync_d;
  logic                 valid_d;

  // Saturate a scaled result to the channel range
  function automatic logic [COLOR_W-1:0] clamp(input logic signed [SW-1:0] v);
    if (v < 0) begin
      return '0;
    end
    if (v > MAXV) begin
      return '1;
    end
    return v[COLOR_W-1:0];
  endfunction

  assign pix_in[0] = vid_i.r;
  assign pix_in[1] = vid_i.g;
  assign pix_in[2] = vid_i.b;

  // ========================================
  // Stage 1: nine products
  // ========================================

  always_ff @(posedge VCLK_Tx) begin
    for (int k = 0; k < 9; k++) begin
      prod[k] <= $signed({1'b0, pix_in[k % 3]}) * YPBPR_COEF[k];
    end
    // Bypass copy keeps the RGB path the same length
    rgb_d  <= pix_in;
    sync_d <= vid_i.sync;
  end

  // ========================================
  // Stage 2: sums, scale, offset, clamp
  // ========================================

  // Rows Y, Pb, Pr, floor division by 256
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      sum[i] = (prod[3*i] + prod[3*i+1] + prod[3*i+2]) >>> COEF_SHIFT;
    end
  end

  always_ff @(posedge VCLK_Tx) begin
    vid_o.sync <= sync_d;
    if (cfg_i.en_ypbpr) begin
      // Pr in red, Y in green, Pb in blue
      vid_o.r <= clamp(sum[2] + OFFSET);
      vid_o.g <= clamp(sum[0]);
      vid_o.b <= clamp(sum[1] + OFFSET);
    end else begin
      vid_o.r <= rgb_d[0];
      vid_o.g <= rgb_d[1];
      vid_o.b <= rgb_d[2];
    end
  end

  // Valid flag follows both stages
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      valid_d     <= 1'b0;
      vid_o.valid <= 1'b0;
    end else begin
      valid_d     <= vid_i.valid;
      vid_o.valid <= valid_d;
    end
  end

endmodule

// File: verilog/ppu_vout.sv
// Output stage: colour with R/B swap, composite sync and sync/filter pins
`timescale 1ns/1ps

module ppu_vout #(
  parameter int COLOR_W = 8
) (
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,
  input  ppu_cfg_pkg::ppu_cfg_t cfg_i,
  ppu_video_if.snk              vid_i,
  output logic [3*COLOR_W-1:0]  vd_o,
  output logic [1:0]            ncsync_o,
  output logic                  nvsync_or_f2_o,
  output logic                  nhsync_or_f1_o
);

  import ppu_cfg_pkg::*;
  import ppu_video_pkg::*;

  // Filter add-on code
  // 00 SD, 01 ED, 10 HD, 11 bypass
  logic [1:0] filt_q;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vd_o           <= '0;
      ncsync_o       <= 2'b00;
      filt_q         <= 2'b00;
      nvsync_or_f2_o <= 1'b0;
      nhsync_or_f1_o <= 1'b0;
    end else begin
      // Auto picks the code from the line multiplier setting
      if (cfg_i.filter_sel == FILT_AUTO) begin
        filt_q <= cfg_i.linemult;
      end else begin
        filt_q <= cfg_i.filter_sel[1:0] - 2'd1;
      end

      // Picture and composite sync move only with the stream
      if (vid_i.valid) begin
        vd_o        <= cfg_i.exchange_rb ? {vid_i.b, vid_i.g, vid_i.r}
                                         : {vid_i.r, vid_i.g, vid_i.b};
        ncsync_o[1] <= vid_i.sync[SYNC_C];
        // Sync on green only for RGsB or YPbPr
        ncsync_o[0] <= (cfg_i.en_rgsb | cfg_i.en_ypbpr) ? vid_i.sync[SYNC_C] : 1'b0;
      end

      // VGA syncs on valid pixels, else filter code every cycle
      if (cfg_i.use_vga_hvsync) begin
        if (vid_i.valid) begin
          nvsync_or_f2_o <= vid_i.sync[SYNC_V];
          nhsync_or_f1_o <= vid_i.sync[SYNC_H];
        end
      end else begin
        nvsync_or_f2_o <= filt_q[1];
        nhsync_or_f1_o <= filt_q[0];
      end
    end
  end

endmodule

// File: verilog/ppu_out_top.sv
// Top level: register bank, line tracker, position counter and pixel pipeline
`timescale 1ns/1ps

module ppu_out_top #(
  parameter int COLOR_W = 8,
  parameter int POS_W   = 10
) (
  input  logic                          VCLK_Tx,
  input  logic                          nVRST_Tx,
  // Incoming pixel stream
  input  logic                          vdata_valid_i,
  input  logic [3*COLOR_W-1:0]          vd_i,
  input  logic [3:0]                    vsync_i,
  // Wishbone classic slave
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [1:0]                    wb_adr_i,
  input  logic [ppu_cfg_pkg::WB_DW-1:0] wb_dat_i,
  output logic [ppu_cfg_pkg::WB_DW-1:0] wb_dat_o,
  output logic                          wb_ack_o,
  // Video output pins
  output logic [3*COLOR_W-1:0]          vd_o,
  output logic [1:0]                    ncsync_o,
  output logic                          nvsync_or_f2_o,
  output logic                          nhsync_or_f1_o
);

  import ppu_cfg_pkg::*;

  ppu_cfg_t         cfg;
  logic [7:0]       frame_lines;
  logic             line_start;
  logic             frame_start;
  logic             in_frame;
  logic [POS_W-1:0] pos_x;
  logic [POS_W-1:0] pos_y;

  // Stream after the input stage and after the matrix
  ppu_video_if #(.COLOR_W(COLOR_W)) vid_tp ();
  ppu_video_if #(.COLOR_W(COLOR_W)) vid_cv ();

  // ========================================
  // Configuration
  // ========================================

  ppu_cfg_wb u_cfg_wb (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .frame_lines_i (frame_lines),
    .cfg_o         (cfg)
  );

  // ========================================
  // Line and frame tracking
  // ========================================

  ppu_line_fsm u_line_fsm (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .vdata_valid_i (vdata_valid_i),
    .vsync_i       (vsync_i),
    .line_start_o  (line_start),
    .frame_start_o (frame_start),
    .in_frame_o    (in_frame)
  );

  ppu_pos_counter #(.POS_W(POS_W)) u_pos_counter (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .vdata_valid_i (vdata_valid_i),
    .line_start_i  (line_start),
    .frame_start_i (frame_start),
    .in_frame_i    (in_frame),
    .x_o           (pos_x),
    .y_o           (pos_y),
    .frame_lines_o (frame_lines)
  );

  // ========================================
  // Pixel pipeline, four cycles in total
  // ========================================

  ppu_testpat #(.COLOR_W(COLOR_W), .POS_W(POS_W)) u_testpat (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .vdata_valid_i (vdata_valid_i),
    .vd_i          (vd_i),
    .vsync_i       (vsync_i),
    .x_i           (pos_x),
    .y_i           (pos_y),
    .cfg_i         (cfg),
    .vid_o         (vid_tp.src)
  );

  ppu_vconv #(.COLOR_W(COLOR_W)) u_vconv (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .cfg_i    (cfg),
    .vid_i    (vid_tp.snk),
    .vid_o    (vid_cv.src)
  );

  ppu_vout #(.COLOR_W(COLOR_W)) u_vout (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .cfg_i          (cfg),
    .vid_i          (vid_cv.snk),
    .vd_o           (vd_o),
    .ncsync_o       (ncsync_o),
    .nvsync_or_f2_o (nvsync_or_f2_o),
    .nhsync_or_f1_o (nhsync_or_f1_o)
  );

endmodule

// File: bench/ppu_out_tb.sv
// Testbench for ppu_out_top: clock, reset, Wishbone tasks, stimulus, reference model, checker
`timescale 1ns/1ps

module ppu_out_tb;

  import ppu_cfg_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int N_RAND     = 200;
  localparam int N_PINS     = 50;
  localparam int LINE_W     = 40;
  localparam int N_LINES    = 20;
  // Each pixel takes at most two cycles, gap included
  localparam int STIM_CYCLES = 2 * (3 * N_RAND + 2 * N_PINS + LINE_W * N_LINES + 16);
  localparam int WB_CYCLES   = 40 * 3;
  localparam int WATCHDOG_NS = (STIM_CYCLES + WB_CYCLES + 400) * CLK_PERIOD;

  // One expected output pixel, due at a given cycle count
  typedef struct packed {
    logic [31:0] due;
    logic [23:0] vd;
    logic [1:0]  cs;
    logic        pins_on;
    logic [1:0]  pins;
  } exp_t;

  logic             VCLK_Tx;
  logic             nVRST_Tx;
  logic             vdata_valid_i;
  logic [23:0]      vd_i;
  logic [3:0]       vsync_i;
  logic             wb_cyc_i;
  logic             wb_stb_i;
  logic             wb_we_i;
  logic [1:0]       wb_adr_i;
  logic [WB_DW-1:0] wb_dat_i;
  logic [WB_DW-1:0] wb_dat_o;
  logic             wb_ack_o;
  logic [23:0]      vd_o;
  logic [1:0]       ncsync_o;
  logic             nvsync_or_f2_o;
  logic             nhsync_or_f1_o;

  // Model state
  exp_t        exp_q [$];
  exp_t        cur_exp;
  logic [31:0] cyc = '0;
  logic [7:0]  ctrl_sh;
  logic [7:0]  filt_sh;
  integer      seed = 6314;
  int          err_cnt;
  int          test_err0;
  int          tests_run;
  int          tests_bad;
  string       cur_test;

  ppu_out_top #(.COLOR_W(8), .POS_W(10)) dut_i (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .vdata_valid_i  (vdata_valid_i),
    .vd_i           (vd_i),
    .vsync_i        (vsync_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .vd_o           (vd_o),
    .ncsync_o       (ncsync_o),
    .nvsync_or_f2_o (nvsync_or_f2_o),
    .nhsync_or_f1_o (nhsync_or_f1_o)
  );

  initial begin
    VCLK_Tx = 1'b0;
    forever #(CLK_PERIOD / 2) VCLK_Tx = ~VCLK_Tx;
  end

  // Cycle count, read on the falling edge only
  always @(posedge VCLK_Tx) cyc <= cyc + 32'd1;

  // ========================================
  // Reference model and check
  // ========================================

  function automatic int sat8(input int v);
    if (v < 0) return 0;
    if (v > 255) return 255;
    return v;
  endfunction

  // Expected colour: checker, matrix with floor shift and offset, R/B swap
  function automatic logic [23:0] ref_pixel(input logic [23:0] pix, input int x, input int y,
                                            input logic [7:0] ctrl);
    int r;
    int g;
    int b;
    int yv;
    int pb;
    int pr;
    int t;
    r = int'(pix[23:16]);
    g = int'(pix[15:8]);
    b = int'(pix[7:0]);
    if (ctrl[0]) begin
      r = ((x[3] ^ y[3]) == 1'b1) ? 255 : 0;
      g = r;
      b = r;
    end
    if (ctrl[2]) begin
      yv = (77 * r + 150 * g + 29 * b) >>> 8;
      pb = ((-43 * r - 85 * g + 128 * b) >>> 8) + 128;
      pr = ((128 * r - 107 * g - 21 * b) >>> 8) + 128;
      r  = sat8(pr);
      g  = sat8(yv);
      b  = sat8(pb);
    end
    if (ctrl[1]) begin
      t = r;
      r = b;
      b = t;
    end
    return {r[7:0], g[7:0], b[7:0]};
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("** Error in %s (%s): expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
    end
  endtask

  // Output compare, stable half a cycle after the DUT edge
  always @(negedge VCLK_Tx) begin
    if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      cur_exp = exp_q.pop_front();
      check_val("vd_o", 32'(cur_exp.vd), 32'(vd_o));
      check_val("ncsync_o", 32'(cur_exp.cs), 32'(ncsync_o));
      if (cur_exp.pins_on) begin
        check_val("vga sync pins", 32'(cur_exp.pins), 32'({nvsync_or_f2_o, nhsync_or_f1_o}));
      end
    end
  end

  // ========================================
  // Stimulus tasks
  // ========================================

  task automatic send_pixel(input logic [23:0] pix, input logic [3:0] sync,
                            input int x, input int y);
    exp_t e;
    @(negedge VCLK_Tx);
    vdata_valid_i = 1'b1;
    vd_i          = pix;
    vsync_i       = sync;
    // Four register stages from input to pins
    e.due     = cyc + 32'd4;
    e.vd      = ref_pixel(pix, x, y, ctrl_sh);
    e.cs      = {sync[0], (ctrl_sh[3] | ctrl_sh[2]) ? sync[0] : 1'b0};
    e.pins_on = ctrl_sh[4];
    e.pins    = {sync[3], sync[1]};
    exp_q.push_back(e);
  endtask

  task automatic insert_gap();
    @(negedge VCLK_Tx);
    vdata_valid_i = 1'b0;
  endtask

  // Random pixels and syncs, optional saturated channels, random idle gaps
  task automatic run_random(input int n, input bit sat);
    logic [23:0] pix;
    logic [3:0]  sync;
    for (int i = 0; i < n; i++) begin
      pix = 24'($random(seed));
      if (sat && (i % 4 == 0)) pix = {{8{pix[0]}}, {8{pix[1]}}, {8{pix[2]}}};
      sync = 4'($random(seed));
      send_pixel(pix, sync, 0, 0);
      if (($random(seed) & 7) == 0) insert_gap();
    end
  endtask

  // Stop the stream and wait for every expected pixel
  task automatic drain_pipe();
    int n;
    insert_gap();
    n = 0;
    while (exp_q.size() != 0 && n < 8) begin
      @(negedge VCLK_Tx);
      n++;
    end
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("Pipeline in %s left %0d pixels undelivered", cur_test, exp_q.size());
      exp_q.delete();
    end
  endtask

  // ========================================
  // Wishbone master
  // ========================================

  task automatic wb_access(input logic [1:0] adr, input logic we, input logic [WB_DW-1:0] wdat,
                           output logic [WB_DW-1:0] rdat);
    @(negedge VCLK_Tx);
    check_val("ack idle", 32'd0, 32'(wb_ack_o));
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    // Ack one cycle after strobe
    @(negedge VCLK_Tx);
    check_val("ack rise", 32'd1, 32'(wb_ack_o));
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    // Single-cycle ack
    @(negedge VCLK_Tx);
    check_val("ack fall", 32'd0, 32'(wb_ack_o));
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [WB_DW-1:0] data);
    logic [WB_DW-1:0] unused;
    wb_access(adr, 1'b1, data, unused);
    // Register model, STATUS and unmapped addresses ignore writes
    case (adr)
      CFG_CTRL:   ctrl_sh = {3'b000, data[4:0]};
      CFG_FILTER: filt_sh = {2'b00, data[5:4], 1'b0, data[2:0]};
      default:    ;
    endcase
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [WB_DW-1:0] data);
    wb_access(adr, 1'b0, '0, data);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = err_cnt;
    tests_run++;
  endtask

  task automatic finish_test();
    if (err_cnt != test_err0) tests_bad++;
    $display("test %s: %s, %0d mismatches", cur_test,
             (err_cnt == test_err0) ? "ok" : "failing", err_cnt - test_err0);
  endtask

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    logic [WB_DW-1:0] rd;
    logic [3:0]       sync;
    logic [1:0]       code;
    vdata_valid_i = 1'b0;
    vd_i          = '0;
    vsync_i       = 4'hF;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    ctrl_sh       = '0;
    filt_sh       = '0;
    err_cnt       = 0;
    tests_run     = 0;
    tests_bad     = 0;
    nVRST_Tx      = 1'b0;
    repeat (3) @(posedge VCLK_Tx);
    @(negedge VCLK_Tx);
    nVRST_Tx = 1'b1;

    // Reset values and register access
    start_test("registers");
    check_val("vd_o reset", 32'd0, 32'(vd_o));
    check_val("ncsync reset", 32'd0, 32'(ncsync_o));
    check_val("pins reset", 32'd0, 32'({nvsync_or_f2_o, nhsync_or_f1_o}));
    wb_read(CFG_STATUS, rd);
    check_val("STATUS reset", 32'd0, 32'(rd));
    wb_write(CFG_CTRL, 8'h15);
    wb_read(CFG_CTRL, rd);
    check_val("CTRL", 32'(ctrl_sh), 32'(rd));
    wb_write(CFG_FILTER, 8'h23);
    wb_read(CFG_FILTER, rd);
    check_val("FILTER", 32'(filt_sh), 32'(rd));
    wb_write(CFG_CTRL, 8'hEA);
    wb_read(CFG_CTRL, rd);
    check_val("CTRL high bits", 32'(ctrl_sh), 32'(rd));
    wb_write(CFG_STATUS, 8'h5A);
    wb_read(CFG_STATUS, rd);
    check_val("STATUS write", 32'd0, 32'(rd));
    wb_write(2'd3, 8'hFF);
    wb_read(2'd3, rd);
    check_val("unmapped", 32'd0, 32'(rd));
    wb_read(CFG_CTRL, rd);
    check_val("CTRL kept", 32'(ctrl_sh), 32'(rd));
    wb_write(CFG_CTRL, 8'h00);
    wb_write(CFG_FILTER, 8'h00);
    finish_test();

    // Plain RGB, then with R and B exchanged
    start_test("pass_through");
    run_random(N_RAND, 1'b0);
    drain_pipe();
    wb_write(CFG_CTRL, 8'h02);
    run_random(N_RAND, 1'b0);
    drain_pipe();
    finish_test();

    start_test("ypbpr");
    wb_write(CFG_CTRL, 8'h04);
    run_random(N_RAND, 1'b1);
    drain_pipe();
    finish_test();

    // Idle syncs first so both edges land on pixel 0 of line 0
    start_test("test_pattern");
    wb_write(CFG_CTRL, 8'h00);
    for (int i = 0; i < 4; i++) send_pixel(24'($random(seed)), 4'hF, 0, 0);
    drain_pipe();
    wb_write(CFG_CTRL, 8'h01);
    for (int l = 0; l < N_LINES; l++) begin
      for (int x = 0; x < LINE_W; x++) begin
        // H low for 4 pixels, V low for the first 2 lines, blank bit idle
        sync[1] = (x >= 4);
        sync[3] = (l >= 2);
        sync[2] = 1'b1;
        sync[0] = sync[1] & sync[3];
        send_pixel(24'($random(seed)), sync, x, l);
      end
    end
    // Next vertical edge closes the frame
    send_pixel(24'($random(seed)), 4'b0100, 0, 0);
    send_pixel(24'($random(seed)), 4'b0100, 1, 0);
    drain_pipe();
    wb_read(CFG_STATUS, rd);
    check_val("STATUS lines", 32'(N_LINES), 32'(rd));
    finish_test();

    // Sync on green, VGA syncs, then filter codes
    start_test("sync_pins");
    wb_write(CFG_CTRL, 8'h08);
    run_random(N_PINS, 1'b0);
    drain_pipe();
    wb_write(CFG_CTRL, 8'h10);
    run_random(N_PINS, 1'b0);
    drain_pipe();
    wb_write(CFG_CTRL, 8'h00);
    for (int i = 0; i < 8; i++) begin
      // Auto with each line multiplier, then SD, ED, HD, bypass
      wb_write(CFG_FILTER, (i < 4) ? 8'(i << 4) : 8'(i - 3));
      @(negedge VCLK_Tx);
      code = (filt_sh[2:0] == 3'd0) ? filt_sh[5:4] : 2'(filt_sh[2:0] - 3'd1);
      check_val("filter pins", 32'(code), 32'({nvsync_or_f2_o, nhsync_or_f1_o}));
    end
    finish_test();

    $display("summary: %0d tests, %0d failing, %0d mismatches", tests_run, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the stimulus lengths
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: vlog.f
verilog/ppu_cfg_pkg.sv
verilog/ppu_video_pkg.sv
verilog/ppu_video_if.sv
verilog/ppu_cfg_wb.sv
verilog/ppu_line_fsm.sv
verilog/ppu_pos_counter.sv
verilog/ppu_testpat.sv
verilog/ppu_vconv.sv
verilog/ppu_vout.sv
verilog/ppu_out_top.sv
bench/ppu_out_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ppu_out_tb simulation with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f vlog.f --top-module ppu_out_tb \
  -Mdir "$BUILD_DIR" -o ppu_out_tb
if [ $? -ne 0 ]; then
  echo "run_sim: Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/ppu_out_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "run_sim: simulation exited with status $sim_status"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
  echo "run_sim: simulation passed"
  exit 0
else
  echo "run_sim: pass message not found in $LOG"
  exit 1
fi
